//--- Makefile
# Verilator build and run of the NI AXI4 slave testbench
VERILATOR ?= verilator
TOP       ?= tb_ni_axi_slave
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# Build, run, then pass only if the log holds the pass message
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- src/ni_axi_rd.sv
//******************************
// AXI4 read path, packet-in flits to AR/R bursts
// pkt_in_vc_i must be below NUM_VC, other VCs are never accepted
// Empty VC is judged when AR is accepted, later beats wait for flits
//******************************
`timescale 1ns/100ps

module ni_axi_rd #(
  parameter int NUM_VC   = 3,
  parameter int OT_DEPTH = 4,
  parameter int RX_DEPTH = 8
) (
  input  logic                      clk_axi,
  input  logic                      arst_axi,
  // AR channel
  input  logic                      arvalid_i,
  output logic                      arready_o,
  input  logic [ni_pkg::ID_W-1:0]   arid_i,
  input  logic [ni_pkg::ADDR_W-1:0] araddr_i,
  input  logic [ni_pkg::LEN_W-1:0]  arlen_i,
  input  logic [2:0]                arsize_i,
  input  logic [1:0]                arburst_i,
  // R channel
  output logic                      rvalid_o,
  input  logic                      rready_i,
  output logic [ni_pkg::ID_W-1:0]   rid_o,
  output logic [ni_pkg::DATA_W-1:0] rdata_o,
  output ni_pkg::resp_t             rresp_o,
  output logic                      rlast_o,
  // Packet-in port from the router
  input  logic                      pkt_in_valid_i,
  output logic                      pkt_in_ready_o,
  input  logic [ni_pkg::DATA_W-1:0] pkt_in_data_i,
  input  logic [ni_pkg::VC_W-1:0]   pkt_in_vc_i
);
  import ni_pkg::*;

  ot_req_t          ot_in;
  ot_req_t          rd_head;
  logic             ot_full;
  logic             ot_empty;
  logic             ot_push;
  logic [VC_W-1:0]  ar_vc;
  logic             ar_vc_empty;
  logic             ar_err;
  // Per-VC receive buffers
  data_t            rx_data [NUM_VC];
  logic [NUM_VC-1:0] rx_full;
  logic [NUM_VC-1:0] rx_empty;
  logic [NUM_VC-1:0] rx_write;
  logic [NUM_VC-1:0] rx_read;
  logic             in_full;
  logic             sel_empty;
  data_t            sel_data;
  // Head burst walker
  logic             txn_q;
  logic [LEN_W-1:0] beat_q;
  logic             r_hs;
  logic             r_done;

  //******************************
  // VC lookups
  //******************************
  // Unknown VCs read as empty and full
  always_comb begin
    ar_vc_empty = 1'b1;
    in_full     = 1'b1;
    sel_empty   = 1'b1;
    sel_data    = '0;
    for (int i = 0; i < NUM_VC; i++) begin
      if (ar_vc == VC_W'(i)) begin
        ar_vc_empty = rx_empty[i];
      end
      if (pkt_in_vc_i == VC_W'(i)) begin
        in_full = rx_full[i];
      end
      if (rd_head.vc == VC_W'(i)) begin
        sel_empty = rx_empty[i];
        sel_data  = rx_data[i];
      end
    end
  end

  assign pkt_in_ready_o = !in_full;

  //******************************
  // AR decode and OT queue
  //******************************
  assign arready_o = !ot_full;
  assign ot_push   = arvalid_i && arready_o;
  assign ar_vc     = araddr_i[VC_LSB +: VC_W];

  assign ar_err = (arburst_i != BURST_INCR) ||
                  (arsize_i != SIZE_WORD) ||
                  (araddr_i[ADDR_W-1 -: 4] != REGION_RX) ||
                  (int'(ar_vc) >= NUM_VC) ||
                  ar_vc_empty;

  assign ot_in = '{id: arid_i, len: arlen_i, vc: ar_vc, err: ar_err};

  ni_fifo #(
    .DEPTH     (OT_DEPTH),
    .payload_t (ot_req_t)
  ) u_ot_rd (
    .clk_axi  (clk_axi),
    .arst_axi (arst_axi),
    .write_i  (ot_push),
    .read_i   (r_done),
    .data_i   (ot_in),
    .data_o   (rd_head),
    .full_o   (ot_full),
    .empty_o  (ot_empty)
  );

  // One buffer per VC, each R beat of a good burst pops one flit
  for (genvar g = 0; g < NUM_VC; g++) begin : gen_rx_buf
    assign rx_write[g] = pkt_in_valid_i && (pkt_in_vc_i == VC_W'(g));
    assign rx_read[g]  = r_hs && !rd_head.err && (rd_head.vc == VC_W'(g));

    ni_fifo #(
      .DEPTH     (RX_DEPTH),
      .payload_t (data_t)
    ) u_rx_buf (
      .clk_axi  (clk_axi),
      .arst_axi (arst_axi),
      .write_i  (rx_write[g]),
      .read_i   (rx_read[g]),
      .data_i   (pkt_in_data_i),
      .data_o   (rx_data[g]),
      .full_o   (rx_full[g]),
      .empty_o  (rx_empty[g])
    );
  end

  //******************************
  // R channel
  //******************************
  // Error burst is a single SLVERR beat with zero data
  assign rvalid_o = txn_q && (rd_head.err || !sel_empty);
  assign rid_o    = rd_head.id;
  assign rdata_o  = rd_head.err ? '0 : sel_data;
  assign rresp_o  = rd_head.err ? SLVERR : OKAY;
  assign rlast_o  = rvalid_o && (rd_head.err || (beat_q == rd_head.len));
  assign r_hs     = rvalid_o && rready_i;
  assign r_done   = r_hs && rlast_o;

  // txn_q opens a cycle after an entry reaches the head
  always_ff @(posedge clk_axi or posedge arst_axi) begin
    if (arst_axi) begin
      txn_q  <= 1'b0;
      beat_q <= '0;
    end else if (r_done) begin
      txn_q  <= 1'b0;
      beat_q <= '0;
    end else begin
      if (!ot_empty) begin
        txn_q <= 1'b1;
      end
      if (r_hs) begin
        beat_q <= beat_q + 1'b1;
      end
    end
  end

endmodule

//--- src/ni_axi_slave.sv
//******************************
// NI AXI4 slave top, write and read paths side by side
// 16-bit decoded address, 32-bit data, INCR word bursts only
// No CSR region, interrupts or clock crossing
//******************************
`timescale 1ns/100ps

module ni_axi_slave #(
  parameter int NUM_VC   = 3,
  parameter int OT_DEPTH = 4,
  parameter int RX_DEPTH = 8
) (
  input  logic                      clk_axi,
  input  logic                      arst_axi,
  // AW channel
  input  logic                      awvalid_i,
  output logic                      awready_o,
  input  logic [ni_pkg::ID_W-1:0]   awid_i,
  input  logic [ni_pkg::ADDR_W-1:0] awaddr_i,
  input  logic [ni_pkg::LEN_W-1:0]  awlen_i,
  input  logic [2:0]                awsize_i,
  input  logic [1:0]                awburst_i,
  // W channel
  input  logic                      wvalid_i,
  output logic                      wready_o,
  input  logic [ni_pkg::DATA_W-1:0] wdata_i,
  input  logic                      wlast_i,
  // B channel
  output logic                      bvalid_o,
  input  logic                      bready_i,
  output logic [ni_pkg::ID_W-1:0]   bid_o,
  output ni_pkg::resp_t             bresp_o,
  // AR channel
  input  logic                      arvalid_i,
  output logic                      arready_o,
  input  logic [ni_pkg::ID_W-1:0]   arid_i,
  input  logic [ni_pkg::ADDR_W-1:0] araddr_i,
  input  logic [ni_pkg::LEN_W-1:0]  arlen_i,
  input  logic [2:0]                arsize_i,
  input  logic [1:0]                arburst_i,
  // R channel
  output logic                      rvalid_o,
  input  logic                      rready_i,
  output logic [ni_pkg::ID_W-1:0]   rid_o,
  output logic [ni_pkg::DATA_W-1:0] rdata_o,
  output ni_pkg::resp_t             rresp_o,
  output logic                      rlast_o,
  // Packet-out to the router
  output logic                      pkt_out_valid_o,
  input  logic                      pkt_out_ready_i,
  output logic [ni_pkg::DATA_W-1:0] pkt_out_data_o,
  output logic [ni_pkg::VC_W-1:0]   pkt_out_vc_o,
  output logic                      pkt_out_new_o,
  output logic                      pkt_out_last_o,
  output logic [ni_pkg::LEN_W-1:0]  pkt_out_len_o,
  // Packet-in from the router
  input  logic                      pkt_in_valid_i,
  output logic                      pkt_in_ready_o,
  input  logic [ni_pkg::DATA_W-1:0] pkt_in_data_i,
  input  logic [ni_pkg::VC_W-1:0]   pkt_in_vc_i
);

  // Port names match the sub-blocks one to one
  // AW/W/B and packet-out
  ni_axi_wr #(
    .NUM_VC   (NUM_VC),
    .OT_DEPTH (OT_DEPTH)
  ) u_axi_wr (.*);

  // AR/R and packet-in
  ni_axi_rd #(
    .NUM_VC   (NUM_VC),
    .OT_DEPTH (OT_DEPTH),
    .RX_DEPTH (RX_DEPTH)
  ) u_axi_rd (.*);

endmodule

//--- src/ni_axi_wr.sv
//******************************
// AXI4 write path, AW/W/B to packet-out flits
// W beats stall while a B response waits for bready
// Error bursts are swallowed and answered with SLVERR
//******************************
`timescale 1ns/100ps

module ni_axi_wr #(
  parameter int NUM_VC   = 3,
  parameter int OT_DEPTH = 4
) (
  input  logic                      clk_axi,
  input  logic                      arst_axi,
  // AW channel
  input  logic                      awvalid_i,
  output logic                      awready_o,
  input  logic [ni_pkg::ID_W-1:0]   awid_i,
  input  logic [ni_pkg::ADDR_W-1:0] awaddr_i,
  input  logic [ni_pkg::LEN_W-1:0]  awlen_i,
  input  logic [2:0]                awsize_i,
  input  logic [1:0]                awburst_i,
  // W channel
  input  logic                      wvalid_i,
  output logic                      wready_o,
  input  logic [ni_pkg::DATA_W-1:0] wdata_i,
  input  logic                      wlast_i,
  // B channel
  output logic                      bvalid_o,
  input  logic                      bready_i,
  output logic [ni_pkg::ID_W-1:0]   bid_o,
  output ni_pkg::resp_t             bresp_o,
  // Packet-out port to the router
  output logic                      pkt_out_valid_o,
  input  logic                      pkt_out_ready_i,
  output logic [ni_pkg::DATA_W-1:0] pkt_out_data_o,
  output logic [ni_pkg::VC_W-1:0]   pkt_out_vc_o,
  output logic                      pkt_out_new_o,
  output logic                      pkt_out_last_o,
  output logic [ni_pkg::LEN_W-1:0]  pkt_out_len_o
);
  import ni_pkg::*;

  ot_req_t         ot_in;
  ot_req_t         ot_head;
  logic            ot_full;
  logic            ot_empty;
  logic            ot_push;
  logic            ot_pop;
  logic [VC_W-1:0] aw_vc;
  logic            aw_err;
  logic            b_free;
  logic            w_hs;
  logic            head_flit_q;

  //******************************
  // AW decode and OT queue
  //******************************
  assign awready_o = !ot_full;
  assign ot_push   = awvalid_i && awready_o;
  assign aw_vc     = awaddr_i[VC_LSB +: VC_W];

  // Anything outside the TX region, including RX, is an error
  assign aw_err = (awburst_i != BURST_INCR) ||
                  (awsize_i != SIZE_WORD) ||
                  (awaddr_i[ADDR_W-1 -: 4] != REGION_TX) ||
                  (int'(aw_vc) >= NUM_VC);

  assign ot_in = '{id: awid_i, len: awlen_i, vc: aw_vc, err: aw_err};

  ni_fifo #(
    .DEPTH     (OT_DEPTH),
    .payload_t (ot_req_t)
  ) u_ot_wr (
    .clk_axi  (clk_axi),
    .arst_axi (arst_axi),
    .write_i  (ot_push),
    .read_i   (ot_pop),
    .data_i   (ot_in),
    .data_o   (ot_head),
    .full_o   (ot_full),
    .empty_o  (ot_empty)
  );

  //******************************
  // W beats to flits
  //******************************
  // B register can take a new response this cycle
  assign b_free = !bvalid_o || bready_i;

  // Error entries drain W without the router
  assign wready_o = !ot_empty && b_free && (ot_head.err || pkt_out_ready_i);
  assign w_hs     = wvalid_i && wready_o;
  assign ot_pop   = w_hs && wlast_i;

  assign pkt_out_valid_o = wvalid_i && !ot_empty && b_free && !ot_head.err;
  assign pkt_out_data_o  = wdata_i;
  assign pkt_out_vc_o    = ot_head.vc;
  assign pkt_out_new_o   = head_flit_q;
  assign pkt_out_last_o  = wlast_i;
  assign pkt_out_len_o   = ot_head.len;

  // Head flag rearms after the last beat of every burst
  always_ff @(posedge clk_axi or posedge arst_axi) begin
    if (arst_axi) begin
      head_flit_q <= 1'b1;
      bvalid_o    <= 1'b0;
    end else begin
      if (w_hs) begin
        head_flit_q <= wlast_i;
      end
      if (ot_pop) begin
        bvalid_o <= 1'b1;
      end else if (bready_i) begin
        bvalid_o <= 1'b0;
      end
    end
  end

  // B payload captured with the last beat, entry pops on the same edge
  always_ff @(posedge clk_axi) begin
    if (ot_pop) begin
      bid_o   <= ot_head.id;
      bresp_o <= ot_head.err ? SLVERR : OKAY;
    end
  end

endmodule

//--- src/ni_fifo.sv
//******************************
// Synchronous FIFO, head entry shown combinationally on data_o
// Writes when full and reads when empty are dropped
// Storage has no reset, only pointers are cleared
//******************************
`timescale 1ns/100ps

module ni_fifo #(
  parameter int  DEPTH     = 4,
  parameter type payload_t = logic
) (
  input  logic     clk_axi,
  input  logic     arst_axi,
  input  logic     write_i,
  input  logic     read_i,
  input  payload_t data_i,
  output payload_t data_o,
  output logic     full_o,
  output logic     empty_o
);
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  // Wrap bits tell full from empty when the pointers meet
  logic             wr_wrap;
  logic             rd_wrap;
  logic             do_write;
  logic             do_read;

  assign empty_o  = (wr_ptr == rd_ptr) && (wr_wrap == rd_wrap);
  assign full_o   = (wr_ptr == rd_ptr) && (wr_wrap != rd_wrap);
  assign do_write = write_i && !full_o;
  assign do_read  = read_i && !empty_o;
  assign data_o   = mem[rd_ptr];

  // Pointers step to zero after DEPTH-1, so any depth works
  always_ff @(posedge clk_axi or posedge arst_axi) begin
    if (arst_axi) begin
      wr_ptr  <= '0;
      wr_wrap <= 1'b0;
      rd_ptr  <= '0;
      rd_wrap <= 1'b0;
    end else begin
      if (do_write) begin
        if (wr_ptr == PTR_W'(DEPTH - 1)) begin
          wr_ptr  <= '0;
          wr_wrap <= ~wr_wrap;
        end else begin
          wr_ptr <= wr_ptr + 1'b1;
        end
      end
      if (do_read) begin
        if (rd_ptr == PTR_W'(DEPTH - 1)) begin
          rd_ptr  <= '0;
          rd_wrap <= ~rd_wrap;
        end else begin
          rd_ptr <= rd_ptr + 1'b1;
        end
      end
    end
  end

  // Storage
  always_ff @(posedge clk_axi) begin
    if (do_write) begin
      mem[wr_ptr] <= data_i;
    end
  end

endmodule

//--- src/ni_pkg.sv
//******************************
// Shared widths, address map and types for the NI AXI4 slave
// Only address bits 15:0 are decoded, upper bits are ignored
// Only INCR bursts of 4-byte beats are serviced
//******************************
package ni_pkg;

  //******************************
  // Bus widths
  //******************************
  localparam int DATA_W = 32;
  localparam int ADDR_W = 16;
  localparam int ID_W   = 4;
  localparam int LEN_W  = 8;
  localparam int VC_W   = 2;

  //******************************
  // Address map
  //******************************
  // Region code sits in address bits 15:12
  localparam logic [3:0] REGION_TX = 4'h1;
  localparam logic [3:0] REGION_RX = 4'h2;
  // VC index sits in address bits 4:3
  localparam int         VC_LSB    = 3;

  // AXI burst and size codes that are accepted
  localparam logic [1:0] BURST_INCR = 2'b01;
  localparam logic [2:0] SIZE_WORD  = 3'b010;

  // AXI response codes, EXOKAY and DECERR are never returned
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } resp_t;

  // Flit payload and AXI data word
  typedef logic [DATA_W-1:0] data_t;

  // One outstanding AW or AR request, 15 bits
  typedef struct packed {
    logic [ID_W-1:0]  id;
    logic [LEN_W-1:0] len;
    logic [VC_W-1:0]  vc;
    logic             err;
  } ot_req_t;

endpackage

//--- test/ni_axi_slave_properties.sv
//******************************
// Concurrent checks bound into ni_axi_slave
// Stability under back-pressure on B, R and packet-out
// Response valids are low while reset is held
//******************************
`timescale 1ns/100ps

module ni_axi_slave_properties (
  input logic                      clk_axi,
  input logic                      arst_axi,
  input logic                      bvalid_o,
  input logic                      bready_i,
  input logic [ni_pkg::ID_W-1:0]   bid_o,
  input logic [1:0]                bresp_o,
  input logic                      rvalid_o,
  input logic                      rready_i,
  input logic [ni_pkg::ID_W-1:0]   rid_o,
  input logic [ni_pkg::DATA_W-1:0] rdata_o,
  input logic [1:0]                rresp_o,
  input logic                      rlast_o,
  input logic                      pkt_out_valid_o,
  input logic                      pkt_out_ready_i,
  input logic [ni_pkg::DATA_W-1:0] pkt_out_data_o,
  input logic [ni_pkg::VC_W-1:0]   pkt_out_vc_o,
  input logic                      pkt_out_new_o,
  input logic                      pkt_out_last_o,
  input logic [ni_pkg::LEN_W-1:0]  pkt_out_len_o
);

  // Stalled B keeps its payload
  b_hold: assert property (@(posedge clk_axi) disable iff (arst_axi)
    bvalid_o && !bready_i |=> bvalid_o && $stable(bid_o) && $stable(bresp_o))
    else $error("B response changed while stalled");

  // Stalled R beat keeps its payload
  r_hold: assert property (@(posedge clk_axi) disable iff (arst_axi)
    rvalid_o && !rready_i |=> rvalid_o && $stable(rid_o) && $stable(rdata_o) &&
    $stable(rresp_o) && $stable(rlast_o))
    else $error("R beat changed while stalled");

  pkt_hold: assert property (@(posedge clk_axi) disable iff (arst_axi)
    pkt_out_valid_o && !pkt_out_ready_i |=> pkt_out_valid_o &&
    $stable(pkt_out_data_o) && $stable(pkt_out_vc_o) && $stable(pkt_out_new_o) &&
    $stable(pkt_out_last_o) && $stable(pkt_out_len_o))
    else $error("Packet-out flit changed while stalled");

  reset_low: assert property (@(posedge clk_axi)
    arst_axi |-> !bvalid_o && !rvalid_o && !pkt_out_valid_o)
    else $error("Valid output high during reset");

  // Next burst opens no earlier than the cycle after RLAST is taken
  last_gap: assert property (@(posedge clk_axi) disable iff (arst_axi)
    rvalid_o && rready_i && rlast_o |=> !rvalid_o)
    else $error("R beat offered right after the last beat of a burst");

endmodule

bind ni_axi_slave ni_axi_slave_properties ni_axi_slave_props_i (.*);

//--- test/ni_testdata.hex
// Columns: op id addr len burst size resp d0 d1 d2 d3 (VC from addr bits 4:3)
// op 1 push flits, 2 write burst, 3 read burst, 4 wait idle, 0 end; resp 0 OKAY, 2 SLVERR
1 0 0000 3 0 0 0 A0000001 A0000002 A0000003 A0000004
1 0 0008 1 0 0 0 B0000001 B0000002 00000000 00000000
2 3 1000 3 1 2 0 11110000 11110001 11110002 11110003
2 5 1008 0 1 2 0 22220000 00000000 00000000 00000000
2 6 1010 2 1 2 0 33330000 33330001 33330002 00000000
2 7 1000 1 2 2 2 44440000 44440001 00000000 00000000
2 8 1008 0 1 0 2 55550000 00000000 00000000 00000000
2 9 3000 1 1 2 2 66660000 66660001 00000000 00000000
2 A 1018 0 1 2 2 77770000 00000000 00000000 00000000
2 B 2000 0 1 2 2 88880000 00000000 00000000 00000000
3 1 2000 1 1 2 0 00000000 00000000 00000000 00000000
3 2 2008 1 1 2 0 00000000 00000000 00000000 00000000
3 4 2000 1 1 2 0 00000000 00000000 00000000 00000000
3 5 3000 0 1 2 2 00000000 00000000 00000000 00000000
3 6 2010 0 2 2 2 00000000 00000000 00000000 00000000
4 0 0000 0 0 0 0 00000000 00000000 00000000 00000000
3 7 2008 0 1 2 2 00000000 00000000 00000000 00000000
1 0 0010 2 0 0 0 C0000001 C0000002 C0000003 00000000
3 8 2010 2 1 2 0 00000000 00000000 00000000 00000000
2 C 1008 3 1 2 0 99990000 99990001 99990002 99990003
2 D 1000 1 1 2 0 DDDD0000 DDDD0001 00000000 00000000
3 9 2018 0 1 2 2 00000000 00000000 00000000 00000000
0 0 0000 0 0 0 0 00000000 00000000 00000000 00000000

//--- test/tb_ni_axi_slave.sv
//******************************
// Testbench for the NI AXI4 slave, driven by test/ni_testdata.hex
// Records hold 11 words and carry at most 4 data words, so len <= 3
// Reads rely on flits pushed by earlier records of the same VC
// Run from the project root so the data file path resolves
//******************************
`timescale 1ns/100ps

module tb_ni_axi_slave;
  import ni_pkg::*;

  localparam int          NUM_VC    = 3;
  localparam int          OT_DEPTH  = 4;
  localparam int          RX_DEPTH  = 8;
  localparam int          REC_W     = 11;
  localparam int          MAX_REC   = 32;
  localparam int          CLK_HALF  = 10;
  localparam int          DRIVE_DLY = 2;
  localparam logic [31:0] SEED      = 32'hc6fa3ee5;
  // Opcodes in word 0 of a record
  localparam int OP_END = 0, OP_PUSH = 1, OP_WRITE = 2, OP_READ = 3, OP_SYNC = 4;

  typedef struct packed {
    data_t           data;
    logic [VC_W-1:0] vc;
    logic            first;
    logic            last;
    logic [LEN_W-1:0] len;
  } flit_t;
  typedef struct packed {
    logic [ID_W-1:0] id;
    data_t           data;
    resp_t           resp;
    logic            last;
  } beat_t;
  typedef struct packed {
    logic [ID_W-1:0] id;
    resp_t           resp;
  } b_exp_t;

  // DUT ports
  logic clk_axi, arst_axi;
  logic awvalid_i, awready_o, wvalid_i, wready_o, wlast_i, bvalid_o, bready_i;
  logic arvalid_i, arready_o, rvalid_o, rready_i, rlast_o;
  logic [ID_W-1:0] awid_i, bid_o, arid_i, rid_o;
  logic [ADDR_W-1:0] awaddr_i, araddr_i;
  logic [LEN_W-1:0] awlen_i, arlen_i, pkt_out_len_o;
  logic [2:0] awsize_i, arsize_i;
  logic [1:0] awburst_i, arburst_i;
  data_t wdata_i, rdata_o, pkt_out_data_o, pkt_in_data_i;
  resp_t bresp_o, rresp_o;
  logic pkt_out_valid_o, pkt_out_ready_i, pkt_out_new_o, pkt_out_last_o;
  logic pkt_in_valid_i, pkt_in_ready_o;
  logic [VC_W-1:0] pkt_out_vc_o, pkt_in_vc_i;

  // Test data and scoreboard state
  logic [31:0] tdata [REC_W*MAX_REC];
  flit_t  flit_q [$];
  beat_t  beat_q [$];
  b_exp_t b_q [$];
  int     w_q [$];
  // Reference model of the receive buffers, one queue per VC code
  data_t  rx_model [4][$];
  int     mismatch_cnt = 0;
  int     other_cnt = 0;
  int     cycle_cnt = 0;
  int     cycle_limit = 0;
  int     num_rec;

  ni_axi_slave #(
    .NUM_VC   (NUM_VC),
    .OT_DEPTH (OT_DEPTH),
    .RX_DEPTH (RX_DEPTH)
  ) ni_axi_slave_i (.*);

  //******************************
  // Compare tasks
  //******************************
  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("ERROR %s got %h expected %h", name, got, exp);
      mismatch_cnt++;
    end
  endtask

  task automatic check_resp(input string name, input resp_t got, input resp_t exp);
    if (got !== exp) begin
      $display("ERROR %s got %h expected %h", name, got, exp);
      mismatch_cnt++;
    end
  endtask

  task automatic check_id(input string name, input logic [ID_W-1:0] got,
                          input logic [ID_W-1:0] exp);
    if (got !== exp) begin
      $display("ERROR %s got %h expected %h", name, got, exp);
      mismatch_cnt++;
    end
  endtask

  task automatic check_vc(input string name, input logic [VC_W-1:0] got,
                          input logic [VC_W-1:0] exp);
    if (got !== exp) begin
      $display("ERROR %s got %h expected %h", name, got, exp);
      mismatch_cnt++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERROR %s got %h expected %h", name, got, exp);
      mismatch_cnt++;
    end
  endtask

  task automatic check_len(input string name, input logic [LEN_W-1:0] got,
                           input logic [LEN_W-1:0] exp);
    if (got !== exp) begin
      $display("ERROR %s got %h expected %h", name, got, exp);
      mismatch_cnt++;
    end
  endtask

  //******************************
  // Helpers
  //******************************
  function automatic logic [31:0] field(input int r, input int k);
    return tdata[r * REC_W + k];
  endfunction

  // VC index from address bits 4:3
  function automatic int addr_vc(input int r);
    return int'((field(r, 2) >> VC_LSB) & 32'h3);
  endfunction

  // Inputs change a short delay after the rising edge
  task automatic next_drive();
    @(posedge clk_axi);
    #DRIVE_DLY;
  endtask

  task automatic push_flits(input int r);
    int n;
    n = int'(field(r, 3)) + 1;
    for (int k = 0; k < n; k++) begin
      pkt_in_valid_i = 1'b1;
      pkt_in_vc_i    = VC_W'(addr_vc(r));
      pkt_in_data_i  = field(r, 7 + k);
      @(negedge clk_axi);
      while (!pkt_in_ready_o) @(negedge clk_axi);
      rx_model[addr_vc(r)].push_back(pkt_in_data_i);
      next_drive();
    end
    pkt_in_valid_i = 1'b0;
  endtask

  task automatic run_write(input int r);
    flit_t  f;
    b_exp_t be;
    int     n;
    n         = int'(field(r, 3)) + 1;
    awvalid_i = 1'b1;
    awid_i    = ID_W'(field(r, 1));
    awaddr_i  = ADDR_W'(field(r, 2));
    awlen_i   = LEN_W'(field(r, 3));
    awburst_i = 2'(field(r, 4));
    awsize_i  = 3'(field(r, 5));
    @(negedge clk_axi);
    while (!awready_o) @(negedge clk_axi);
    next_drive();
    awvalid_i = 1'b0;
    be.id   = ID_W'(field(r, 1));
    be.resp = resp_t'(2'(field(r, 6)));
    b_q.push_back(be);
    // A good burst turns into len+1 flits, an error burst into none
    if (be.resp == OKAY) begin
      for (int k = 0; k < n; k++) begin
        f.data  = field(r, 7 + k);
        f.vc    = VC_W'(addr_vc(r));
        f.first = (k == 0);
        f.last  = (k == n - 1);
        f.len   = LEN_W'(field(r, 3));
        flit_q.push_back(f);
      end
    end
    w_q.push_back(r);
  endtask

  task automatic run_read(input int r);
    beat_t b;
    int    n;
    n         = int'(field(r, 3)) + 1;
    arvalid_i = 1'b1;
    arid_i    = ID_W'(field(r, 1));
    araddr_i  = ADDR_W'(field(r, 2));
    arlen_i   = LEN_W'(field(r, 3));
    arburst_i = 2'(field(r, 4));
    arsize_i  = 3'(field(r, 5));
    @(negedge clk_axi);
    while (!arready_o) @(negedge clk_axi);
    next_drive();
    arvalid_i = 1'b0;
    b.id   = ID_W'(field(r, 1));
    b.resp = resp_t'(2'(field(r, 6)));
    if (b.resp == OKAY) begin
      // Data comes back in push order for this VC
      for (int k = 0; k < n; k++) begin
        b.last = (k == n - 1);
        if (rx_model[addr_vc(r)].size() == 0) begin
          $display("Read record %0d asks for more flits than were pushed", r);
          other_cnt++;
          b.data = '0;
        end else begin
          b.data = rx_model[addr_vc(r)].pop_front();
        end
        beat_q.push_back(b);
      end
    end else begin
      b.data = '0;
      b.last = 1'b1;
      beat_q.push_back(b);
    end
  endtask

  task automatic wait_idle();
    while (w_q.size() != 0 || flit_q.size() != 0 || b_q.size() != 0 ||
           beat_q.size() != 0) begin
      @(negedge clk_axi);
    end
    next_drive();
  endtask

  //******************************
  // Clock, ready gaps, W driver
  //******************************
  initial begin : clock_gen
    clk_axi = 1'b0;
    forever #CLK_HALF clk_axi = ~clk_axi;
  end

  // Sink and master ready each drop one cycle in four on average
  initial begin : ready_gen
    void'($urandom(SEED));
    forever begin
      next_drive();
      pkt_out_ready_i = ($urandom % 4) != 0;
      bready_i        = ($urandom % 4) != 0;
      rready_i        = ($urandom % 4) != 0;
    end
  end

  initial begin : w_driver
    int r;
    int n;
    @(negedge arst_axi);
    forever begin
      if (w_q.size() == 0) begin
        next_drive();
      end else begin
        r = w_q.pop_front();
        n = int'(field(r, 3)) + 1;
        for (int k = 0; k < n; k++) begin
          wvalid_i = 1'b1;
          wdata_i  = field(r, 7 + k);
          wlast_i  = (k == n - 1);
          @(negedge clk_axi);
          while (!wready_o) @(negedge clk_axi);
          next_drive();
        end
        wvalid_i = 1'b0;
        wlast_i  = 1'b0;
      end
    end
  end

  //******************************
  // Monitors, sampled mid-cycle
  //******************************
  always @(negedge clk_axi) begin
    flit_t  f;
    beat_t  b;
    b_exp_t be;
    if (arst_axi == 1'b0) begin
      if (pkt_out_valid_o && pkt_out_ready_i) begin
        if (flit_q.size() == 0) begin
          $display("Unexpected flit on packet-out with data %h", pkt_out_data_o);
          other_cnt++;
        end else begin
          f = flit_q.pop_front();
          check_data("pkt_out_data_o", pkt_out_data_o, f.data);
          check_vc("pkt_out_vc_o", pkt_out_vc_o, f.vc);
          check_flag("pkt_out_new_o", pkt_out_new_o, f.first);
          check_flag("pkt_out_last_o", pkt_out_last_o, f.last);
          check_len("pkt_out_len_o", pkt_out_len_o, f.len);
        end
      end
      if (bvalid_o && bready_i) begin
        if (b_q.size() == 0) begin
          $display("Unexpected write response with ID %h", bid_o);
          other_cnt++;
        end else begin
          be = b_q.pop_front();
          check_id("bid_o", bid_o, be.id);
          check_resp("bresp_o", bresp_o, be.resp);
        end
      end
      if (rvalid_o && rready_i) begin
        if (beat_q.size() == 0) begin
          $display("Unexpected read beat with ID %h", rid_o);
          other_cnt++;
        end else begin
          b = beat_q.pop_front();
          check_id("rid_o", rid_o, b.id);
          check_data("rdata_o", rdata_o, b.data);
          check_resp("rresp_o", rresp_o, b.resp);
          check_flag("rlast_o", rlast_o, b.last);
        end
      end
    end
  end

  //******************************
  // Timeout
  //******************************
  initial begin : watchdog
    while (cycle_limit == 0 || cycle_cnt <= cycle_limit) begin
      @(posedge clk_axi);
      cycle_cnt++;
    end
    $display("Timeout, the run did not finish within %0d cycles", cycle_limit);
    $display("TESTBENCH FAILED");
    $finish;
  end

  //******************************
  // Main sequence
  //******************************
  initial begin : main_seq
    int op;
    arst_axi        = 1'b1;
    awvalid_i       = 1'b0;
    awid_i          = '0;
    awaddr_i        = '0;
    awlen_i         = '0;
    awsize_i        = '0;
    awburst_i       = '0;
    wvalid_i        = 1'b0;
    wdata_i         = '0;
    wlast_i         = 1'b0;
    bready_i        = 1'b0;
    arvalid_i       = 1'b0;
    arid_i          = '0;
    araddr_i        = '0;
    arlen_i         = '0;
    arsize_i        = '0;
    arburst_i       = '0;
    rready_i        = 1'b0;
    pkt_out_ready_i = 1'b0;
    pkt_in_valid_i  = 1'b0;
    pkt_in_data_i   = '0;
    pkt_in_vc_i     = '0;
    for (int i = 0; i < REC_W * MAX_REC; i++) begin
      tdata[i] = '0;
    end
    $readmemh("test/ni_testdata.hex", tdata);
    num_rec = 0;
    while (num_rec < MAX_REC && field(num_rec, 0) != OP_END) begin
      num_rec++;
    end
    cycle_limit = 64 * num_rec + 200;
    repeat (4) @(posedge clk_axi);
    #DRIVE_DLY;
    arst_axi = 1'b0;
    next_drive();
    for (int r = 0; r < num_rec; r++) begin
      op = int'(field(r, 0));
      case (op)
        OP_PUSH:  push_flits(r);
        OP_WRITE: run_write(r);
        OP_READ:  run_read(r);
        OP_SYNC:  wait_idle();
        default: begin
          $display("Unknown opcode %0d in record %0d", op, r);
          other_cnt++;
        end
      endcase
    end
    wait_idle();
    // Idle cycles catch any extra flit or beat
    repeat (8) next_drive();
    $display("Errors: %0d value mismatches, %0d other failures", mismatch_cnt, other_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- vlog.f
src/ni_pkg.sv
src/ni_fifo.sv
src/ni_axi_wr.sv
src/ni_axi_rd.sv
src/ni_axi_slave.sv
test/ni_axi_slave_properties.sv
test/tb_ni_axi_slave.sv
